// ==== src/mmuPkg.sv ====
package mmuPkg;

  // Section descriptor layout in the page table word
  // Type field sits in bits 1:0, bit 1 set marks a section
  localparam int descSectionBit = 1;
  localparam int descDomainLsb = 5;
  localparam int descApLsb = 10;
  localparam int descBaseLsb = 20;

  // Descriptor type, bits 1:0 of a first-level entry
  typedef enum logic [1:0] {
    descFault   = 2'b00,
    descCoarse  = 2'b01,
    descSection = 2'b10,
    descFine    = 2'b11
  } descType;

  // Decoded section, also the TLB payload
  typedef struct packed {
    logic [11:0] sectionBase;
    logic [3:0]  domain;
    logic [1:0]  ap;
  } sectionDesc;

  // MMU control bits from the system control register
  typedef struct packed {
    logic enable;
    logic alignCheck;
  } mmuControl;

  // Request held by the CPU until completion
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    // Low for an instruction fetch
    logic        dataAccess;
    logic        supMode;
    logic        wordAccess;
    logic [31:0] wdata;
  } cpuReq;

  // Fault codes, listed in priority order
  typedef enum logic [3:0] {
    faultNone          = 4'b0000,
    faultAlign         = 4'b0001,
    faultSectionTrans  = 4'b0101,
    faultSectionDomain = 4'b1001,
    faultSectionPerm   = 4'b1101
  } faultCode;

  // Fault status register contents
  typedef struct packed {
    logic [3:0] domain;
    faultCode   code;
  } faultStatus;

  // Controller states
  typedef enum logic [2:0] {
    stIdle,
    stWalk,
    stFill,
    stAccess,
    stAbort
  } walkState;

endpackage

// ==== src/tlb.sv ====
module tlb #(
  parameter int tlbEntries = 8
) (
  input  logic               clk,
  input  logic               rst,
  // Invalidate everything
  input  logic               flush,
  // Section number of the held address
  input  logic [11:0]        vtag,
  input  logic               fill,
  input  mmuPkg::sectionDesc fillEntry,
  output logic               hit,
  output mmuPkg::sectionDesc entry
);
  import mmuPkg::*;

  // Pointer width, at least one bit
  localparam int ptrW = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;
  localparam logic [ptrW-1:0] lastIdx = ptrW'(tlbEntries - 1);

  logic [tlbEntries-1:0] valid;
  logic [11:0]           tags [tlbEntries];
  sectionDesc            descs [tlbEntries];
  // Round-robin victim
  logic [ptrW-1:0]       ptr;

  // Valid bits and victim pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      ptr   <= '0;
    end else if (flush) begin
      valid <= '0;
    end else if (fill) begin
      valid[ptr] <= 1'b1;
      // Wrap at the last entry
      if (ptr == lastIdx) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // Tag and payload storage
  always_ff @(posedge clk) begin
    if (fill) begin
      tags[ptr]  <= vtag;
      descs[ptr] <= fillEntry;
    end
  end

  // Parallel compare
  // Fill only happens on a miss so at most one entry matches
  always_comb begin
    hit   = 1'b0;
    entry = '0;
    for (int i = 0; i < tlbEntries; i++) begin
      if (valid[i] && tags[i] == vtag) begin
        hit   = 1'b1;
        entry = descs[i];
      end
    end
  end

endmodule

// ==== src/faultCheck.sv ====
module faultCheck (
  input  logic               clk,
  input  logic               rst,
  input  mmuPkg::mmuControl  control,
  input  mmuPkg::cpuReq      req,
  input  mmuPkg::sectionDesc desc,
  // Low on a miss or an invalid walked entry
  input  logic               descValid,
  input  logic [31:0]        domainAccess,
  input  logic               abortStrobe,
  output mmuPkg::faultCode   code,
  output mmuPkg::faultStatus fStatus,
  output logic [31:0]        faultAddr
);
  import mmuPkg::*;

  logic [1:0] domBits;
  logic       misaligned;
  logic       permFault;

  // Two access bits per domain
  assign domBits = domainAccess[{desc.domain, 1'b0} +: 2];

  assign misaligned = control.alignCheck && req.wordAccess && (req.addr[1:0] != 2'b00);

  // ap decode for client domains
  always_comb begin
    case (desc.ap)
      2'b00:   permFault = 1'b1;
      2'b01:   permFault = !req.supMode;
      // User read only
      2'b10:   permFault = !req.supMode && req.write;
      default: permFault = 1'b0;
    endcase
  end

  // Priority chain
  always_comb begin
    code = faultNone;
    if (!control.enable) begin
      code = faultNone;
    end else if (misaligned) begin
      code = faultAlign;
    end else if (!descValid) begin
      code = faultSectionTrans;
    end else if (domBits == 2'b00 || domBits == 2'b10) begin
      // No access or reserved
      code = faultSectionDomain;
    end else if (domBits == 2'b01 && permFault) begin
      // Manager skips this
      code = faultSectionPerm;
    end
  end

  // Data faults only, fetch faults leave status alone
  always_ff @(posedge clk) begin
    if (rst) begin
      fStatus   <= '0;
      faultAddr <= '0;
    end else if (abortStrobe && req.dataAccess) begin
      fStatus.domain <= desc.domain;
      fStatus.code   <= code;
      faultAddr      <= req.addr;
    end
  end

endmodule

// ==== src/instrTracker.sv ====
module instrTracker (
  input  logic clk,
  input  logic rst,
  // Fetch fault pulse from the walker
  input  logic fetchFault,
  input  logic stallD,
  input  logic flushD,
  input  logic flushE,
  output logic prefetchAbort
);

  // Faulting instruction sitting in decode
  logic pending;
  // Faulting instruction in execute, lasts one cycle
  logic inExec;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      inExec  <= 1'b0;
    end else begin
      inExec <= 1'b0;
      if (flushD) begin
        // Squashed in decode
        pending <= 1'b0;
      end else if (fetchFault) begin
        pending <= 1'b1;
      end else if (pending && !stallD) begin
        // Advances into execute
        pending <= 1'b0;
        inExec  <= 1'b1;
      end
    end
  end

  // Abort unless execute is flushed
  assign prefetchAbort = inExec && !flushE;

endmodule

// ==== src/tableWalk.sv ====
module tableWalk (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  logic               cpuRequest,
  input  mmuPkg::cpuReq      req,
  input  logic [17:0]        tableBase,
  input  logic               tlbHit,
  input  mmuPkg::sectionDesc tlbEntry,
  input  mmuPkg::faultCode   fault,
  output logic               fill,
  output mmuPkg::sectionDesc fillEntry,
  output mmuPkg::sectionDesc walkDesc,
  output logic               useWalkDesc,
  output logic               abortStrobe,
  output logic               dataAbort,
  output logic               fetchDone,
  output logic               cpuReady,
  output logic               hRequest,
  output logic               hWrite,
  output logic [31:0]        hAddr,
  output logic [31:0]        hWData,
  input  logic [31:0]        hRData,
  input  logic               hReady
);
  import mmuPkg::*;

  walkState state;
  walkState next;
  // Captured descriptor from the walk read
  descType  walkType;
  logic     walkValid;
  // Abort came from an invalid walked descriptor
  logic     fromWalk;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= stIdle;
      fromWalk <= 1'b0;
    end else begin
      state    <= next;
      fromWalk <= (state == stFill) && !walkValid;
    end
  end

  // Descriptor fields, taken in the hReady cycle of the walk
  always_ff @(posedge clk) begin
    if (state == stWalk && hReady) begin
      walkType             <= descType'(hRData[descSectionBit -: 2]);
      walkDesc.sectionBase <= hRData[descBaseLsb +: 12];
      walkDesc.domain      <= hRData[descDomainLsb +: 4];
      walkDesc.ap          <= hRData[descApLsb +: 2];
    end
  end

  // Coarse, fine and fault entries all translate-fault
  assign walkValid = (walkType == descSection);

  always_comb begin
    next = state;
    case (state)
      stIdle: begin
        if (enable && cpuRequest) begin
          // Alignment wins over the lookup
          if (fault == faultAlign) begin
            next = stAbort;
          end else if (!tlbHit) begin
            next = stWalk;
          end else if (fault != faultNone) begin
            next = stAbort;
          end else begin
            next = stAccess;
          end
        end
      end
      stWalk:   if (hReady) next = stFill;
      // Valid section goes back for a second lookup
      stFill:   next = walkValid ? stIdle : stAbort;
      stAccess: if (hReady) next = stIdle;
      stAbort:  next = stIdle;
      default:  next = stIdle;
    endcase
  end

  assign fill        = (state == stFill) && walkValid;
  assign fillEntry   = walkDesc;
  assign useWalkDesc = (state == stAbort) && fromWalk;

  // Abort cycle, no bus traffic
  assign abortStrobe = (state == stAbort);
  assign dataAbort   = abortStrobe && req.dataAccess;
  assign fetchDone   = abortStrobe && !req.dataAccess;

  // Bus drive for walk read and final access
  assign hRequest = (state == stWalk) || (state == stAccess);
  assign hWrite   = (state == stAccess) && req.write;
  assign hAddr    = (state == stWalk) ? {tableBase, req.addr[31:20], 2'b00}
                                      : {tlbEntry.sectionBase, req.addr[19:0]};
  assign hWData   = req.wdata;
  assign cpuReady = (state == stAccess) && hReady;

endmodule

// ==== src/mmu.sv ====
module mmu #(
  parameter int tlbEntries = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  mmuPkg::mmuControl  control,
  input  logic [17:0]        tableBase,
  input  logic [31:0]        domainAccess,
  input  logic               tlbFlush,
  // CPU request port
  input  logic               cpuRequest,
  input  mmuPkg::cpuReq      req,
  output logic               cpuReady,
  output logic [31:0]        rdata,
  output logic               dataAbort,
  output logic               fetchDone,
  output logic               prefetchAbort,
  output mmuPkg::faultStatus fStatus,
  output logic [31:0]        faultAddr,
  // Pipeline control for the fetch tracker
  input  logic               stallD,
  input  logic               flushD,
  input  logic               flushE,
  // System bus
  output logic               hRequest,
  output logic               hWrite,
  output logic [31:0]        hAddr,
  output logic [31:0]        hWData,
  input  logic [31:0]        hRData,
  input  logic               hReady
);
  import mmuPkg::*;

  // TLB lookup result
  logic       tlbHit;
  sectionDesc tlbEntry;
  // Fill path from the walker
  logic       fill;
  sectionDesc fillEntry;
  // Descriptor seen by the fault checker
  sectionDesc walkDesc;
  logic       useWalkDesc;
  sectionDesc checkDesc;
  logic       checkValid;
  faultCode   fault;
  logic       abortStrobe;
  // Translated bus side from the walker
  logic        walkRequest;
  logic        walkWrite;
  logic [31:0] walkAddr;
  logic [31:0] walkWData;
  logic        walkReady;

  tableWalk walker (
    .clk(clk), .rst(rst), .enable(control.enable),
    .cpuRequest(cpuRequest), .req(req), .tableBase(tableBase),
    .tlbHit(tlbHit), .tlbEntry(tlbEntry), .fault(fault),
    .fill(fill), .fillEntry(fillEntry),
    .walkDesc(walkDesc), .useWalkDesc(useWalkDesc),
    .abortStrobe(abortStrobe), .dataAbort(dataAbort), .fetchDone(fetchDone),
    .cpuReady(walkReady),
    .hRequest(walkRequest), .hWrite(walkWrite), .hAddr(walkAddr), .hWData(walkWData),
    .hRData(hRData), .hReady(hReady)
  );

  // Tag is the section number from VA bits 31:20
  tlb #(.tlbEntries(tlbEntries)) sectionTlb (
    .clk(clk), .rst(rst), .flush(tlbFlush), .vtag(req.addr[31:20]),
    .fill(fill), .fillEntry(fillEntry), .hit(tlbHit), .entry(tlbEntry)
  );

  // An invalid walked descriptor stands in for the missing entry
  assign checkDesc  = useWalkDesc ? walkDesc : tlbEntry;
  assign checkValid = tlbHit & ~useWalkDesc;

  faultCheck faultUnit (
    .clk(clk), .rst(rst), .control(control), .req(req),
    .desc(checkDesc), .descValid(checkValid), .domainAccess(domainAccess),
    .abortStrobe(abortStrobe), .code(fault), .fStatus(fStatus), .faultAddr(faultAddr)
  );

  // Fetch faults are deferred until execute
  instrTracker tracker (
    .clk(clk), .rst(rst), .fetchFault(fetchDone), .stallD(stallD),
    .flushD(flushD), .flushE(flushE), .prefetchAbort(prefetchAbort)
  );

  // Bypass with MMU off
  assign hRequest = control.enable ? walkRequest : cpuRequest;
  assign hWrite   = control.enable ? walkWrite : req.write;
  assign hAddr    = control.enable ? walkAddr : req.addr;
  assign hWData   = control.enable ? walkWData : req.wdata;
  assign cpuReady = control.enable ? walkReady : (cpuRequest & hReady);

  // Read data only valid with cpuReady
  assign rdata = cpuReady ? hRData : '0;

endmodule

// ==== dv/mmu_sva.sv ====
module mmuChecks (
  input logic        clk,
  input logic        rst,
  input logic        hRequest,
  input logic        hReady,
  input logic        hWrite,
  input logic [31:0] hAddr,
  input logic [31:0] hWData,
  input logic        cpuReady,
  input logic        dataAbort,
  input logic        fetchDone,
  input logic        prefetchAbort,
  input logic [7:0]  fStatus,
  input logic [31:0] faultAddr
);

  // Stalled transfer keeps its address
  addrStable: assert property (@(posedge clk) disable iff (rst)
    hRequest && !hReady |=> hRequest && $stable(hAddr))
    else $error("hAddr changed while the bus was stalled");

  // A request ends one way only
  readyOrAbort: assert property (@(posedge clk) disable iff (rst)
    !(cpuReady && dataAbort))
    else $error("cpuReady and dataAbort high in the same cycle");

  // rdata is excluded, it follows the bus
  knownOutputs: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({hRequest, hWrite, hAddr, hWData, cpuReady, dataAbort,
                 fetchDone, prefetchAbort, fStatus, faultAddr}))
    else $error("MMU output unknown after reset");

endmodule

bind mmu mmuChecks sva (
  .clk(clk), .rst(rst), .hRequest(hRequest), .hReady(hReady), .hWrite(hWrite),
  .hAddr(hAddr), .hWData(hWData), .cpuReady(cpuReady), .dataAbort(dataAbort),
  .fetchDone(fetchDone), .prefetchAbort(prefetchAbort), .fStatus(fStatus),
  .faultAddr(faultAddr)
);

// ==== dv/mmuTb.sv ====
module mmuTb;
  import mmuPkg::*;

  logic        clk = 1'b0;
  logic        rst;
  mmuControl   control;
  logic [17:0] tableBase;
  logic [31:0] domainAccess;
  logic        tlbFlush;
  logic        cpuRequest;
  cpuReq       req;
  logic        cpuReady;
  logic [31:0] rdata;
  logic        dataAbort;
  logic        fetchDone;
  logic        prefetchAbort;
  faultStatus  fStatus;
  logic [31:0] faultAddr;
  logic        stallD;
  logic        flushD;
  logic        flushE;
  logic        hRequest;
  logic        hWrite;
  logic [31:0] hAddr;
  logic [31:0] hWData;
  logic [31:0] hRData = '0;
  logic        hReady = 1'b0;

  // Bus model state
  logic [31:0] tableMem [4096];
  logic [31:0] rngState;
  logic        busy;
  logic [1:0]  waitLeft;
  int          tableReads;
  logic [31:0] lastAccAddr;
  logic        lastAccWrite;
  logic [31:0] lastAccWData;
  // Run bookkeeping
  int          errors;
  int          checks;
  int          cycles;
  int          cycleLimit;

  mmu #(.tlbEntries(4)) dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Table region is tableBase followed by a 14-bit offset
  function automatic logic inTable(input logic [31:0] addr);
    return addr[31:14] == tableBase;
  endfunction

  function automatic logic [31:0] busData(input logic [31:0] addr);
    return inTable(addr) ? tableMem[addr[13:2]] : addr;
  endfunction

  // Bus slave with 0 to 3 random wait cycles
  always @(posedge clk) begin : busModel
    logic [31:0] nextRng;
    if (rst) begin
      hReady       <= 1'b0;
      hRData       <= '0;
      busy         <= 1'b0;
      waitLeft     <= '0;
      rngState     <= 32'h00147134;
      tableReads   <= 0;
      lastAccAddr  <= '0;
      lastAccWrite <= 1'b0;
      lastAccWData <= '0;
    end else if (hReady) begin
      // Transfer completes on this edge
      hReady <= 1'b0;
      busy   <= 1'b0;
      if (inTable(hAddr) && !hWrite) begin
        tableReads <= tableReads + 1;
      end else begin
        lastAccAddr  <= hAddr;
        lastAccWrite <= hWrite;
        lastAccWData <= hWData;
      end
    end else if (hRequest) begin
      if (!busy) begin
        nextRng  = xorshift(rngState);
        rngState <= nextRng;
        if (nextRng[1:0] == 2'd0) begin
          hReady <= 1'b1;
          hRData <= busData(hAddr);
        end else begin
          busy     <= 1'b1;
          waitLeft <= nextRng[1:0] - 2'd1;
        end
      end else if (waitLeft == 2'd0) begin
        hReady <= 1'b1;
        hRData <= busData(hAddr);
      end else begin
        waitLeft <= waitLeft - 2'd1;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("ERROR: run did not finish within %0d cycles", cycleLimit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic void compare(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", name, what, expected, actual);
    end
  endfunction

  // One CPU request through to its completion pulse
  task automatic doAccess(input string name, input logic [31:0] addr, input logic wr,
                          input logic dataAcc, input logic sup, input logic word,
                          input logic flushAfter, input string outcome,
                          input logic [31:0] expPa, input logic [3:0] expCode,
                          input logic [3:0] expDom, input int expWalks);
    cpuReq       r;
    faultStatus  statusBefore;
    int          startReads;
    int          aborts;
    string       seen;
    logic [31:0] readData;
    r.addr       = addr;
    r.write      = wr;
    r.dataAccess = dataAcc;
    r.supMode    = sup;
    r.wordAccess = word;
    r.wdata      = ~addr;
    statusBefore = fStatus;
    startReads   = tableReads;
    @(posedge clk);
    req        <= r;
    cpuRequest <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(cpuReady || dataAbort || fetchDone));
    seen     = cpuReady ? "ok" : (dataAbort ? "dabort" : "fetch");
    readData = rdata;
    cpuRequest <= 1'b0;
    flushD     <= flushAfter && fetchDone;
    @(posedge clk);
    flushD <= 1'b0;
    compare(name, "walks", expWalks, tableReads - startReads);
    if (seen == "ok") begin
      compare(name, "bus address", expPa, lastAccAddr);
      compare(name, "bus write", wr, lastAccWrite);
      if (wr) begin
        compare(name, "write data", r.wdata, lastAccWData);
      end else begin
        compare(name, "rdata", expPa, readData);
      end
    end else if (seen == "dabort") begin
      compare(name, "fault status", {expDom, expCode}, fStatus);
      compare(name, "fault address", addr, faultAddr);
    end else begin
      // Give the tracker time to reach execute
      aborts = 0;
      repeat (8) begin
        @(posedge clk);
        if (prefetchAbort) begin
          aborts++;
        end
      end
      seen = (aborts == 0) ? "none" : "prefetch";
      compare(name, "prefetch abort count", (outcome == "prefetch") ? 1 : 0, aborts);
      compare(name, "fault status after fetch", statusBefore, fStatus);
    end
    checks++;
    if (seen != outcome) begin
      errors++;
      $display("MISMATCH %s outcome expected %s actual %s", name, outcome, seen);
    end
  endtask

  initial begin
    int               fd;
    int               n;
    string            line;
    string            lines [$];
    string            name;
    logic [8*16-1:0]  nameBuf;
    logic [8*10-1:0]  outBuf;
    logic [31:0]      f [11];
    mmuControl        c;
    rst          = 1'b1;
    control      = '0;
    tableBase    = '0;
    domainAccess = '0;
    tlbFlush     = 1'b0;
    cpuRequest   = 1'b0;
    req          = '0;
    stallD       = 1'b0;
    flushD       = 1'b0;
    flushE       = 1'b0;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    cycleLimit   = 0;
    // Bits 1:0 stay zero so unwritten entries translate-fault
    for (int i = 0; i < 4096; i++) begin
      tableMem[i] = {i[11:0], 20'h00000};
    end
    fd = $fopen("dv/mmu_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open dv/mmu_vectors.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      cycleLimit = lines.size() * 40;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      foreach (lines[k]) begin
        case (lines[k][0])
          "C": begin
            n = $sscanf(lines[k], "C %h %h %h %h", f[0], f[1], f[2], f[3]);
            c.enable     = f[0][0];
            c.alignCheck = f[1][0];
            @(posedge clk);
            control      <= c;
            tableBase    <= f[2][17:0];
            domainAccess <= f[3];
            @(posedge clk);
          end
          "T": begin
            n = $sscanf(lines[k], "T %h %h", f[0], f[1]);
            tableMem[f[0][11:0]] = f[1];
          end
          "F": begin
            @(posedge clk);
            tlbFlush <= 1'b1;
            @(posedge clk);
            tlbFlush <= 1'b0;
          end
          "A": begin
            n = $sscanf(lines[k], "A %s %h %h %h %h %h %h %s %h %h %h %d", nameBuf,
                        f[0], f[1], f[2], f[3], f[4], f[5], outBuf, f[6], f[7], f[8], f[9]);
            $sformat(name, "%0s", nameBuf);
            doAccess(name, f[0], f[1][0], f[2][0], f[3][0], f[4][0], f[5][0],
                     $sformatf("%0s", outBuf), f[6], f[7][3:0], f[8][3:0], f[9]);
          end
          default: begin
            errors++;
            $display("ERROR: unknown vector line %0d", k);
          end
        endcase
      end
      $display("Vectors: %0d, checks: %0d, errors: %0d", lines.size(), checks, errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== dv/mmu_vectors.txt ====
# C enable alignCheck tableBase domainAccess | T index descriptor | F flushes the TLB
# A name addr write dataAccess supMode wordAccess flushD outcome pa code domain walks
C 1 0 00010 0000000D
T 001 80100C02
T 002 00000000
T 003 80300C42
T 004 80400802
T 005 80500C22
T 006 80600C22
T 007 80700C22
T 008 80800C22
F
A missFirst 00112340 0 1 0 1 0 ok 80112340 0 0 1
A hitSecond 00100008 0 1 0 1 0 ok 80100008 0 0 0
A hitWrite 00100010 1 1 0 1 0 ok 80100010 0 0 0
C 1 1 00010 0000000D
A alignFault 00100001 0 1 0 1 0 dabort 0 1 0 0
A transFault 00200000 0 1 0 1 0 dabort 0 5 0 1
A domainFault 00300000 0 1 1 1 0 dabort 0 9 2 1
A permFault 00400000 1 1 0 1 0 dabort 0 D 0 1
A permSup 00400004 1 1 1 1 0 ok 80400004 0 0 0
A fetchAbort 00200004 0 0 0 1 0 prefetch 0 0 0 1
A fetchFlushed 00200008 0 0 0 1 1 none 0 0 0 1
A fetchOk 00100020 0 0 0 1 0 ok 80100020 0 0 0
T 001 8A100C02
F
A newBase 00100040 0 1 0 1 0 ok 8A100040 0 0 1
A fill5 00500000 0 1 1 1 0 ok 80500000 0 0 1
A fill6 00600004 0 1 1 1 0 ok 80600004 0 0 1
A fill7 00700008 0 1 1 1 0 ok 80700008 0 0 1
A fill8 0080000C 0 1 1 1 0 ok 8080000C 0 0 1
A evicted 00100044 0 1 0 1 0 ok 8A100044 0 0 1
A stillHit 00800010 0 1 1 1 0 ok 80800010 0 0 0
C 0 1 00010 0000000D
A bypassAlign 00300001 1 1 0 1 0 ok 00300001 0 0 0
A bypassFetch 00200000 0 0 0 1 0 ok 00200000 0 0 0

// ==== src.f ====
src/mmuPkg.sv
src/tlb.sv
src/faultCheck.sv
src/instrTracker.sv
src/tableWalk.sv
src/mmu.sv
dv/mmu_sva.sv
dv/mmuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmuTb -f src.f -o mmuSim

./obj_dir/mmuSim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation failed"
  exit 1
fi
